// ==== memStage_consts.svh ====
//////////////////////////////////////////////////////////////////////
// Width and size constants shared by the memory stage
// Include where widths, TLB size or the bus timeout are needed
//////////////////////////////////////////////////////////////////////

`ifndef MEMSTAGE_CONSTS_SVH
`define MEMSTAGE_CONSTS_SVH

// Data and address width
`define XLEN 32

// Page offset bits for 4 KB pages
`define PAGE_BITS 12

// Virtual and physical page number width
`define VPN_BITS (`XLEN - `PAGE_BITS)

// Fully associative DTLB depth
`define TLB_ENTRIES 8

// Cycles allowed between busReq rising and busAck
`define BUS_TIMEOUT 16

`endif

// ==== lsuPkg.sv ====
//////////////////////////////////////////////////////////////////////
// Load/store request, response and fault types
// Imported by every stage that looks at a request
//////////////////////////////////////////////////////////////////////

`include "memStage_consts.svh"

package lsuPkg;

  // Access kind, LR and SC are the only atomics kept
  typedef enum logic [1:0] {
    opLoad,
    opStore,
    opLr,
    opSc
  } memOp_t;

  // Fault codes carried down the pipeline
  typedef enum logic [2:0] {
    faultNone,
    faultLoadMisaligned,
    faultStoreMisaligned,
    faultLoadPage,
    faultStorePage,
    faultTlbMiss
  } fault_t;

  // Request tag, echoed back in the response
  typedef logic [3:0] tag_t;

  // Request as it enters stage 1
  typedef struct packed {
    memOp_t           op;
    logic [2:0]       funct3;     // Bit 2 set means zero extend
    logic [`XLEN-1:0] adr;
    logic [`XLEN-1:0] writeData;
    tag_t             tag;
  } memReq_t;

  // After the alignment check
  typedef struct packed {
    memReq_t req;
    fault_t  fault;
  } checkedReq_t;

  // Response returned to the core
  typedef struct packed {
    logic [`XLEN-1:0] readData;
    fault_t           fault;
    logic             scFail;
    tag_t             tag;
  } memResp_t;

endpackage

// ==== tlbPkg.sv ====
//////////////////////////////////////////////////////////////////////
// Address translation types
// TLB entry layout and the request after translation
//////////////////////////////////////////////////////////////////////

`include "memStage_consts.svh"

package tlbPkg;

  // One DTLB entry, filled through the write port
  typedef struct packed {
    logic                 valid;
    logic [`VPN_BITS-1:0] vpn;
    logic [`VPN_BITS-1:0] ppn;
    logic                 readable;
    logic                 writable;
    logic                 user;
  } tlbEntry_t;

  // Request with physical address, used by stages 3 and 4
  typedef struct packed {
    lsuPkg::memOp_t   op;
    logic [2:0]       funct3;
    logic [`XLEN-1:0] physAdr;
    logic [`XLEN-1:0] writeData;
    lsuPkg::tag_t     tag;
    lsuPkg::fault_t   fault;
    // Failing SC, never reaches the bus
    logic             squash;
  } physReq_t;

endpackage

// ==== memStageIf.sv ====
//////////////////////////////////////////////////////////////////////
// Valid/ready link between two pipeline stages
// payload_t picks the request type carried on the link
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface memStageIf #(
  parameter type payload_t = logic
);

  // Transfer on a cycle with valid and ready both high
  logic     valid;
  logic     ready;
  payload_t payload;

  // Upstream stage drives valid and payload
  modport producer (
    output valid,
    output payload,
    input  ready
  );

  // Downstream stage answers with ready
  modport consumer (
    input  valid,
    input  payload,
    output ready
  );

endinterface

// ==== accessCheck.sv ====
//////////////////////////////////////////////////////////////////////
// Stage 1 of the memory pipeline
// Width decode and alignment check, one register slot
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "memStage_consts.svh"

module accessCheck import lsuPkg::*; (
  input  logic             clk,
  input  logic             reset,
  input  logic             reqValid,
  output logic             reqReady,
  input  memOp_t           reqOp,
  input  logic [2:0]       reqFunct3,
  input  logic [`XLEN-1:0] reqAdr,
  input  logic [`XLEN-1:0] reqWriteData,
  input  tag_t             reqTag,
  memStageIf.producer      out
);

  logic        misaligned;
  logic        storeLike;
  checkedReq_t checked;

  // Byte always fits, half needs bit 0 clear, word needs both clear
  always_comb begin
    case (reqFunct3[1:0])
      2'b00:   misaligned = 1'b0;
      2'b01:   misaligned = reqAdr[0];
      default: misaligned = |reqAdr[1:0];
    endcase
    // LR and SC are word only
    if ((reqOp == opLr || reqOp == opSc) && reqFunct3[1:0] != 2'b10)
      misaligned = 1'b1;
  end

  assign storeLike = (reqOp == opStore) || (reqOp == opSc);

  always_comb begin
    checked.req.op        = reqOp;
    checked.req.funct3    = reqFunct3;
    checked.req.adr       = reqAdr;
    checked.req.writeData = reqWriteData;
    checked.req.tag       = reqTag;
    if (!misaligned)    checked.fault = faultNone;
    else if (storeLike) checked.fault = faultStoreMisaligned;
    else                checked.fault = faultLoadMisaligned;
  end

  // Slot takes a request when empty or draining this cycle
  assign reqReady = ~out.valid | out.ready;

  always_ff @(posedge clk) begin
    if (reset)         out.valid <= 1'b0;
    else if (reqReady) out.valid <= reqValid;
  end

  always_ff @(posedge clk) begin
    if (reqValid && reqReady) out.payload <= checked;
  end

  // A stalled request keeps valid and all its fields
  payloadHeld: assert property (@(posedge clk) disable iff (reset)
    reqValid && !reqReady |=>
      reqValid && $stable({reqOp, reqFunct3, reqAdr, reqWriteData, reqTag}));

endmodule

// ==== dtlb.sv ====
//////////////////////////////////////////////////////////////////////
// Stage 2, fully associative data TLB
// Translates the page number and checks R, W and U permissions
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "memStage_consts.svh"

module dtlb import lsuPkg::*, tlbPkg::*; (
  input  logic                           clk,
  input  logic                           reset,
  memStageIf.consumer                    in,
  memStageIf.producer                    out,
  input  logic                           translateOn,
  input  logic                           userMode,
  input  logic                           tlbWrite,
  input  logic [$clog2(`TLB_ENTRIES)-1:0] tlbWriteIndex,
  input  tlbEntry_t                      tlbWriteEntry,
  input  logic                           tlbFlush
);

  tlbEntry_t               entries [`TLB_ENTRIES];
  logic [`TLB_ENTRIES-1:0] entryValid;
  logic [`TLB_ENTRIES-1:0] hitVec;
  logic                    tlbHit;
  tlbEntry_t               hitEntry;
  checkedReq_t             inReq;
  logic                    loadLike;
  logic                    permFault;
  physReq_t                translated;

  ////////////////////////////////////////////////////////////////////
  // Entry storage
  ////////////////////////////////////////////////////////////////////

  // Valid bits clear on reset and flush
  always_ff @(posedge clk) begin
    if (reset || tlbFlush) entryValid <= '0;
    else if (tlbWrite)     entryValid[tlbWriteIndex] <= tlbWriteEntry.valid;
  end

  always_ff @(posedge clk) begin
    if (tlbWrite) entries[tlbWriteIndex] <= tlbWriteEntry;
  end

  ////////////////////////////////////////////////////////////////////
  // Lookup
  ////////////////////////////////////////////////////////////////////

  assign inReq = in.payload;

  // Compare virtual page against every entry at once
  always_comb begin
    hitEntry = '0;
    for (int i = 0; i < `TLB_ENTRIES; i++) begin
      hitVec[i] = entryValid[i] && entries[i].vpn == inReq.req.adr[`XLEN-1:`PAGE_BITS];
      if (hitVec[i]) hitEntry = entries[i];
    end
  end

  assign tlbHit   = |hitVec;
  assign loadLike = (inReq.req.op == opLoad) || (inReq.req.op == opLr);

  // Missing read, write or user rights
  assign permFault = (loadLike && !hitEntry.readable) ||
                     (!loadLike && !hitEntry.writable) ||
                     (userMode && !hitEntry.user);

  always_comb begin
    translated.op        = inReq.req.op;
    translated.funct3    = inReq.req.funct3;
    translated.physAdr   = inReq.req.adr;
    translated.writeData = inReq.req.writeData;
    translated.tag       = inReq.req.tag;
    translated.squash    = 1'b0;
    translated.fault     = inReq.fault;
    // Earlier faults pass untouched, bare mode skips all checks
    if (inReq.fault == faultNone && translateOn) begin
      if (!tlbHit)        translated.fault = faultTlbMiss;
      else if (permFault) translated.fault = loadLike ? faultLoadPage : faultStorePage;
      else translated.physAdr = {hitEntry.ppn, inReq.req.adr[`PAGE_BITS-1:0]};
    end
  end

  // Register slot
  assign in.ready = ~out.valid | out.ready;

  always_ff @(posedge clk) begin
    if (reset)         out.valid <= 1'b0;
    else if (in.ready) out.valid <= in.valid;
  end

  always_ff @(posedge clk) begin
    if (in.valid && in.ready) out.payload <= translated;
  end

  // Duplicate mappings would let the last matching entry win silently
  singleHit: assert property (@(posedge clk) disable iff (reset)
    in.valid && translateOn |-> $onehot0(hitVec));

endmodule

// ==== reservation.sv ====
//////////////////////////////////////////////////////////////////////
// Stage 3, load-reserved reservation tracking
// Failing store-conditionals are marked squash here
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "memStage_consts.svh"

module reservation import lsuPkg::*, tlbPkg::*; (
  input  logic        clk,
  input  logic        reset,
  memStageIf.consumer in,
  memStageIf.producer out
);

  physReq_t         req;
  physReq_t         marked;
  logic             accept;
  logic             noFault;
  logic             wordMatch;
  logic             scFail;
  logic             resValid;
  logic [`XLEN-1:2] resAdr;

  assign req     = in.payload;
  assign accept  = in.valid && in.ready;
  assign noFault = req.fault == faultNone;

  // Reserved word hit by this access
  assign wordMatch = resValid && req.physAdr[`XLEN-1:2] == resAdr;
  assign scFail    = req.op == opSc && !wordMatch;

  // Updated only as a clean request transfers in
  always_ff @(posedge clk) begin
    if (reset) begin
      resValid <= 1'b0;
    end else if (accept && noFault) begin
      case (req.op)
        opLr:    resValid <= 1'b1;
        // Any SC ends the reservation
        opSc:    resValid <= 1'b0;
        opStore: if (wordMatch) resValid <= 1'b0;
        default: resValid <= resValid;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept && noFault && req.op == opLr) resAdr <= req.physAdr[`XLEN-1:2];
  end

  always_comb begin
    marked        = req;
    marked.squash = scFail && noFault;
  end

  // Register slot
  assign in.ready = ~out.valid | out.ready;

  always_ff @(posedge clk) begin
    if (reset)         out.valid <= 1'b0;
    else if (in.ready) out.valid <= in.valid;
  end

  always_ff @(posedge clk) begin
    if (accept) out.payload <= marked;
  end

endmodule

// ==== busAccess.sv ====
//////////////////////////////////////////////////////////////////////
// Stage 4, external bus access and response
// One bus request per clean access, subword read extension
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "memStage_consts.svh"

module busAccess import lsuPkg::*, tlbPkg::*; (
  input  logic             clk,
  input  logic             reset,
  memStageIf.consumer      in,
  output logic             respValid,
  input  logic             respReady,
  output logic [`XLEN-1:0] respData,
  output fault_t           respFault,
  output logic             respScFail,
  output tag_t             respTag,
  output logic             busReq,
  output logic             busWrite,
  output logic [`XLEN-1:0] busAdr,
  output logic [`XLEN-1:0] busWriteData,
  output logic [3:0]       busByteEnable,
  input  logic             busAck,
  input  logic [`XLEN-1:0] busReadData
);

  typedef enum logic [1:0] {stIdle, stWaitAck, stResp} busState_t;

  busState_t        state;
  physReq_t         cur;
  logic             skipBus;
  logic [`XLEN-1:0] readReg;
  logic [`XLEN-1:0] laneData;
  logic [`XLEN-1:0] loadData;

  ////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////

  assign in.ready = state == stIdle;
  // Faulted and squashed requests go straight to the response
  assign skipBus  = in.payload.fault != faultNone || in.payload.squash;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= stIdle;
    end else begin
      case (state)
        stIdle:    if (in.valid) state <= skipBus ? stResp : stWaitAck;
        stWaitAck: if (busAck) state <= stResp;
        stResp:    if (respReady) state <= stIdle;
        default:   state <= stIdle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (in.valid && in.ready) cur <= in.payload;
    if (state == stWaitAck && busAck) readReg <= busReadData;
  end

  ////////////////////////////////////////////////////////////////////
  // Bus side
  ////////////////////////////////////////////////////////////////////

  assign busReq   = state == stWaitAck;
  assign busWrite = cur.op == opStore || cur.op == opSc;
  assign busAdr   = {cur.physAdr[`XLEN-1:2], 2'b00};

  // Replicate data into lanes, enables from width and offset
  always_comb begin
    case (cur.funct3[1:0])
      2'b00: begin
        busWriteData  = {4{cur.writeData[7:0]}};
        busByteEnable = 4'b0001 << cur.physAdr[1:0];
      end
      2'b01: begin
        busWriteData  = {2{cur.writeData[15:0]}};
        busByteEnable = cur.physAdr[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        busWriteData  = cur.writeData;
        busByteEnable = 4'b1111;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////
  // Response side
  ////////////////////////////////////////////////////////////////////

  // Shift addressed lanes down, funct3 bit 2 selects zero extension
  always_comb begin
    laneData = readReg >> {cur.physAdr[1:0], 3'b000};
    case (cur.funct3[1:0])
      2'b00:   loadData = {{(`XLEN-8){laneData[7] & ~cur.funct3[2]}}, laneData[7:0]};
      2'b01:   loadData = {{(`XLEN-16){laneData[15] & ~cur.funct3[2]}}, laneData[15:0]};
      default: loadData = laneData;
    endcase
  end

  assign respValid  = state == stResp;
  assign respFault  = cur.fault;
  assign respScFail = cur.squash;
  assign respTag    = cur.tag;

  // SC returns 1 on failure, stores and faults return 0
  always_comb begin
    if (cur.fault != faultNone)  respData = '0;
    else if (cur.op == opSc)     respData = {{(`XLEN-1){1'b0}}, cur.squash};
    else if (cur.op == opStore)  respData = '0;
    else                         respData = loadData;
  end

  // Ack only answers a pending request
  ackOnlyOnReq: assert property (@(posedge clk) disable iff (reset)
    busAck |-> busReq);

  ackInTime: assert property (@(posedge clk) disable iff (reset)
    $rose(busReq) |-> ##[0:`BUS_TIMEOUT] busAck);

endmodule

// ==== dmem.sv ====
//////////////////////////////////////////////////////////////////////
// Memory stage top level
// Chains access check, DTLB, reservation and bus access stages
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "memStage_consts.svh"

module dmem import lsuPkg::*, tlbPkg::*; (
  input  logic                            clk,
  input  logic                            reset,
  // Request from the core
  input  logic                            reqValid,
  output logic                            reqReady,
  input  memOp_t                          reqOp,
  input  logic [2:0]                      reqFunct3,
  input  logic [`XLEN-1:0]                reqAdr,
  input  logic [`XLEN-1:0]                reqWriteData,
  input  tag_t                            reqTag,
  // Response to the core
  output logic                            respValid,
  input  logic                            respReady,
  output logic [`XLEN-1:0]                respData,
  output fault_t                          respFault,
  output logic                            respScFail,
  output tag_t                            respTag,
  // External bus
  output logic                            busReq,
  output logic                            busWrite,
  output logic [`XLEN-1:0]                busAdr,
  output logic [`XLEN-1:0]                busWriteData,
  output logic [3:0]                      busByteEnable,
  input  logic                            busAck,
  input  logic [`XLEN-1:0]                busReadData,
  // TLB management
  input  logic                            tlbWrite,
  input  logic [$clog2(`TLB_ENTRIES)-1:0] tlbWriteIndex,
  input  tlbEntry_t                       tlbWriteEntry,
  input  logic                            tlbFlush,
  input  logic                            translateOn,
  input  logic                            userMode
);

  // Stage links
  memStageIf #(.payload_t(checkedReq_t)) checkedLink ();
  memStageIf #(.payload_t(physReq_t))    transLink ();
  memStageIf #(.payload_t(physReq_t))    resvLink ();

  accessCheck u_accessCheck (
    .clk, .reset, .reqValid, .reqReady, .reqOp, .reqFunct3,
    .reqAdr, .reqWriteData, .reqTag,
    .out (checkedLink)
  );

  dtlb u_dtlb (
    .clk, .reset,
    .in  (checkedLink),
    .out (transLink),
    .translateOn, .userMode, .tlbWrite, .tlbWriteIndex, .tlbWriteEntry, .tlbFlush
  );

  reservation u_reservation (
    .clk, .reset,
    .in  (transLink),
    .out (resvLink)
  );

  busAccess u_busAccess (
    .clk, .reset,
    .in  (resvLink),
    .respValid, .respReady, .respData, .respFault, .respScFail, .respTag,
    .busReq, .busWrite, .busAdr, .busWriteData, .busByteEnable, .busAck, .busReadData
  );

endmodule

// ==== tbClock.sv ====
//////////////////////////////////////////////////////////////////////
// Clock and reset source for the memory stage testbench
// 100 ns clock, reset held high for the first 16 cycles
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tbClock (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Released just after the 16th rising edge
  initial begin
    reset = 1'b1;
    repeat (16) @(posedge clk);
    #1 reset = 1'b0;
  end

endmodule

// ==== dmemTb.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for the memory stage pipeline
// Bus memory model, reference model, directed and random stimulus
// Responses are checked in order against a queue of expected values
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "memStage_consts.svh"

module dmemTb import lsuPkg::*, tlbPkg::*; ();

  localparam int SEED = 32'h169a1daa;

  logic                            clk;
  logic                            reset;
  logic                            reqValid;
  logic                            reqReady;
  memOp_t                          reqOp;
  logic [2:0]                      reqFunct3;
  logic [`XLEN-1:0]                reqAdr;
  logic [`XLEN-1:0]                reqWriteData;
  tag_t                            reqTag;
  logic                            respValid;
  logic                            respReady;
  logic [`XLEN-1:0]                respData;
  fault_t                          respFault;
  logic                            respScFail;
  tag_t                            respTag;
  logic                            busReq;
  logic                            busWrite;
  logic [`XLEN-1:0]                busAdr;
  logic [`XLEN-1:0]                busWriteData;
  logic [3:0]                      busByteEnable;
  logic                            busAck;
  logic [`XLEN-1:0]                busReadData;
  logic                            tlbWrite;
  logic [$clog2(`TLB_ENTRIES)-1:0] tlbWriteIndex;
  tlbEntry_t                       tlbWriteEntry;
  logic                            tlbFlush;
  logic                            translateOn;
  logic                            userMode;

  // One seed variable per process, each starting from SEED
  integer seed = SEED;
  integer busSeed = SEED;
  integer readySeed = SEED;

  // Expected responses and expected bus accesses {write, address}
  memResp_t    expQ [$];
  logic [32:0] busQ [$];
  int          busCount = 0;
  int          expBusCount = 0;
  logic        pressure = 1'b0;
  tag_t        nextTag = '0;

  // Reference state
  logic [`XLEN-1:0] modelMem [256];
  logic [`XLEN-1:0] busMem [256];
  tlbEntry_t        tlbModel [`TLB_ENTRIES];
  logic             modelResValid = 1'b0;
  logic [`XLEN-1:2] modelResWord = '0;
  logic [2:0]       loadKinds [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};

  tbClock u_tbClock (.clk, .reset);

  dmem u_dmem (.*);

  //////////////////////////////////////////////////////////////////////
  // Checking helpers
  //////////////////////////////////////////////////////////////////////

  task automatic stopRun(input string reason);
    $display("%s", reason);
    $display("TEST FAIL");
    $fatal(1, "Run stopped");
  endtask

  task automatic checkEq(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
      stopRun("Value check failed");
    end
  endtask

  // Initial memory contents, every byte depends on the full word index
  function automatic logic [31:0] fillWord(input int a);
    return {8'(a), 8'(a * 7 + 3), 8'(~a), 8'(a ^ 32'hc3)};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic memResp_t expectResp(
    input  memOp_t      op,
    input  logic [2:0]  f3,
    input  logic [31:0] adr,
    input  logic [31:0] wd,
    input  tag_t        tag,
    output logic        useBus,
    output logic [31:0] phys
  );
    memResp_t    r;
    int          size;
    int          off;
    logic        isStore;
    logic        bad;
    logic        hit;
    logic        resMatch;
    tlbEntry_t   e;
    logic [7:0]  idx;
    logic [31:0] lanes;
    logic [31:0] mask;
    r.readData = '0;
    r.fault    = faultNone;
    r.scFail   = 1'b0;
    r.tag      = tag;
    useBus     = 1'b0;
    phys       = adr;
    e          = '0;
    isStore    = (op == opStore) || (op == opSc);
    size       = 1 << f3[1:0];
    // Natural alignment, atomics are words only
    bad = (int'(adr[1:0]) % size) != 0;
    if ((op == opLr || op == opSc) && size != 4) bad = 1'b1;
    if (bad) begin
      r.fault = isStore ? faultStoreMisaligned : faultLoadMisaligned;
      return r;
    end
    if (translateOn) begin
      hit = 1'b0;
      foreach (tlbModel[i]) begin
        if (tlbModel[i].valid && tlbModel[i].vpn == adr[31:12]) begin
          hit = 1'b1;
          e   = tlbModel[i];
        end
      end
      if (!hit) begin
        r.fault = faultTlbMiss;
        return r;
      end
      if ((!isStore && !e.readable) || (isStore && !e.writable) || (userMode && !e.user)) begin
        r.fault = isStore ? faultStorePage : faultLoadPage;
        return r;
      end
      phys = {e.ppn, adr[11:0]};
    end
    // Reservation bookkeeping
    resMatch = modelResValid && modelResWord == phys[31:2];
    if (op == opLr) begin
      modelResValid = 1'b1;
      modelResWord  = phys[31:2];
    end else if (op == opSc) begin
      modelResValid = 1'b0;
      if (!resMatch) begin
        r.scFail   = 1'b1;
        r.readData = 32'd1;
        return r;
      end
    end else if (op == opStore && resMatch) begin
      modelResValid = 1'b0;
    end
    useBus = 1'b1;
    idx    = phys[9:2];
    off    = int'(phys[1:0]);
    if (isStore) begin
      for (int b = 0; b < size; b++) modelMem[idx][8*(off+b) +: 8] = wd[8*b +: 8];
    end else begin
      lanes      = modelMem[idx] >> (8 * off);
      mask       = (size == 4) ? 32'hffff_ffff : ((32'd1 << (8 * size)) - 32'd1);
      r.readData = lanes & mask;
      // Signed forms copy the top bit of the selected lanes
      if (size != 4 && !f3[2] && lanes[8*size-1]) r.readData = r.readData | ~mask;
    end
    return r;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////////////////////////

  task automatic sendReq(input memOp_t op, input logic [2:0] f3, input logic [31:0] adr,
                         input logic [31:0] wd);
    memResp_t    exp;
    logic        useBus;
    logic [31:0] phys;
    int          waitCnt;
    exp = expectResp(op, f3, adr, wd, nextTag, useBus, phys);
    expQ.push_back(exp);
    if (useBus) begin
      busQ.push_back({(op == opStore) || (op == opSc), phys[31:2], 2'b00});
      expBusCount++;
    end
    reqValid     = 1'b1;
    reqOp        = op;
    reqFunct3    = f3;
    reqAdr       = adr;
    reqWriteData = wd;
    reqTag       = nextTag;
    nextTag      = nextTag + 4'd1;
    waitCnt      = 0;
    // reqReady only moves on clock edges
    while (!reqReady) begin
      @(posedge clk);
      #1;
      waitCnt++;
      if (waitCnt > 200) stopRun("Timed out waiting for reqReady");
    end
    @(posedge clk);
    #1;
    reqValid = 1'b0;
  endtask

  // Wait until every issued request has answered
  task automatic drain();
    int waitCnt;
    waitCnt = 0;
    while (expQ.size() != 0) begin
      @(posedge clk);
      #1;
      waitCnt++;
      if (waitCnt > 2000) stopRun("Timed out waiting for outstanding responses");
    end
    @(posedge clk);
    #1;
  endtask

  task automatic writeTlb(input int index, input logic [19:0] vpn, input logic [19:0] ppn,
                          input logic r, input logic w, input logic u);
    tlbEntry_t e;
    e.valid         = 1'b1;
    e.vpn           = vpn;
    e.ppn           = ppn;
    e.readable      = r;
    e.writable      = w;
    e.user          = u;
    tlbModel[index] = e;
    tlbWrite        = 1'b1;
    tlbWriteIndex   = index[$clog2(`TLB_ENTRIES)-1:0];
    tlbWriteEntry   = e;
    @(posedge clk);
    #1;
    tlbWrite = 1'b0;
  endtask

  task automatic flushTlb();
    foreach (tlbModel[i]) tlbModel[i].valid = 1'b0;
    tlbFlush = 1'b1;
    @(posedge clk);
    #1;
    tlbFlush = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Bus memory model
  //////////////////////////////////////////////////////////////////////

  initial begin
    int          delay;
    logic        pending;
    logic [32:0] expBus;
    logic [7:0]  idx;
    busAck      = 1'b0;
    busReadData = '0;
    pending     = 1'b0;
    delay       = 0;
    foreach (busMem[i]) busMem[i] = fillWord(i);
    forever begin
      @(posedge clk);
      #1;
      busAck = 1'b0;
      if (busReq) begin
        // New access, check it and pick a 0 to 3 cycle delay
        if (!pending) begin
          pending = 1'b1;
          delay   = $random(busSeed) & 3;
          busCount++;
          if (busQ.size() == 0) stopRun("Bus request seen with no bus access expected");
          expBus = busQ.pop_front();
          checkEq("busWrite", 32'(busWrite), 32'(expBus[32]));
          checkEq("busAdr", busAdr, expBus[31:0]);
        end
        if (delay == 0) begin
          idx = busAdr[9:2];
          if (busWrite) begin
            for (int b = 0; b < 4; b++) begin
              if (busByteEnable[b]) busMem[idx][8*b +: 8] = busWriteData[8*b +: 8];
            end
          end
          busReadData = busMem[idx];
          busAck      = 1'b1;
          pending     = 1'b0;
        end else begin
          delay--;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Response side, drives respReady and compares
  //////////////////////////////////////////////////////////////////////

  initial begin
    memResp_t exp;
    respReady = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      if (pressure) respReady = ($random(readySeed) & 32'h1) == 32'h0;
      else          respReady = 1'b1;
      #1;
      // Transfer happens at the coming edge
      if (respValid && respReady) begin
        if (expQ.size() == 0) stopRun("Response seen with no request outstanding");
        exp = expQ.pop_front();
        checkEq("respData", respData, exp.readData);
        checkEq("respFault", 32'(respFault), 32'(exp.fault));
        checkEq("respScFail", 32'(respScFail), 32'(exp.scFail));
        checkEq("respTag", 32'(respTag), 32'(exp.tag));
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    int          waitCnt;
    int          pick;
    int          kind;
    logic [31:0] adr;
    logic [31:0] wd;
    reqValid      = 1'b0;
    reqOp         = opLoad;
    reqFunct3     = 3'd0;
    reqAdr        = '0;
    reqWriteData  = '0;
    reqTag        = '0;
    tlbWrite      = 1'b0;
    tlbWriteIndex = '0;
    tlbWriteEntry = '0;
    tlbFlush      = 1'b0;
    translateOn   = 1'b0;
    userMode      = 1'b0;
    foreach (modelMem[i]) modelMem[i] = fillWord(i);
    foreach (tlbModel[i]) tlbModel[i] = '0;
    // Reset is known high from the first edge on
    @(posedge clk);
    #1;
    waitCnt = 0;
    while (reset) begin
      @(posedge clk);
      #1;
      waitCnt++;
      if (waitCnt > 100) stopRun("Reset was never released");
    end
    checkEq("reqReady after reset", 32'(reqReady), 32'd1);
    checkEq("respValid after reset", 32'(respValid), 32'd0);
    checkEq("busReq after reset", 32'(busReq), 32'd0);

    // Misaligned accesses fault and stay off the bus
    sendReq(opLoad, 3'b001, 32'h101, 32'h0);
    sendReq(opLoad, 3'b010, 32'h102, 32'h0);
    sendReq(opLoad, 3'b101, 32'h105, 32'h0);
    sendReq(opStore, 3'b001, 32'h103, 32'h1111);
    sendReq(opStore, 3'b010, 32'h101, 32'h2222);
    sendReq(opLr, 3'b001, 32'h100, 32'h0);
    sendReq(opSc, 3'b010, 32'h106, 32'h3333);
    drain();
    checkEq("bus requests after misaligned", 32'(busCount), 32'd0);

    // Subword stores then every load width and sign
    sendReq(opStore, 3'b010, 32'h40, 32'h8bad_f00d);
    sendReq(opStore, 3'b000, 32'h45, 32'h0000_00a5);
    sendReq(opStore, 3'b001, 32'h4a, 32'h0000_8001);
    for (int a = 32'h40; a < 32'h4c; a++) begin
      foreach (loadKinds[k]) sendReq(opLoad, loadKinds[k], a, 32'h0);
    end

    // LR/SC pairs, lost reservations
    sendReq(opLr, 3'b010, 32'h80, 32'h0);
    sendReq(opSc, 3'b010, 32'h80, 32'h1234_5678);
    sendReq(opLoad, 3'b010, 32'h80, 32'h0);
    sendReq(opSc, 3'b010, 32'h80, 32'hdead_beef);
    sendReq(opLr, 3'b010, 32'h84, 32'h0);
    sendReq(opStore, 3'b000, 32'h86, 32'h77);
    sendReq(opSc, 3'b010, 32'h84, 32'hcafe_f00d);
    sendReq(opLoad, 3'b010, 32'h84, 32'h0);
    drain();

    // Entries start invalid out of reset
    translateOn = 1'b1;
    sendReq(opLoad, 3'b010, 32'h1234_5010, 32'h0);
    drain();

    // Translation with R, W and U permission cases
    writeTlb(0, 20'h12345, 20'h00000, 1'b1, 1'b1, 1'b1);
    writeTlb(1, 20'h00010, 20'h00001, 1'b1, 1'b0, 1'b1);
    writeTlb(2, 20'h00020, 20'h00002, 1'b0, 1'b1, 1'b1);
    writeTlb(3, 20'h00030, 20'h00003, 1'b1, 1'b1, 1'b0);
    translateOn = 1'b1;
    userMode    = 1'b1;
    sendReq(opLoad, 3'b010, 32'h1234_5010, 32'h0);
    sendReq(opStore, 3'b010, 32'h1234_5020, 32'h0bad_cafe);
    sendReq(opLoad, 3'b010, 32'h1234_5020, 32'h0);
    sendReq(opLoad, 3'b100, 32'h0001_0041, 32'h0);
    sendReq(opStore, 3'b000, 32'h0001_0041, 32'h5);
    sendReq(opLoad, 3'b010, 32'h0002_0000, 32'h0);
    sendReq(opLr, 3'b010, 32'h0002_0008, 32'h0);
    sendReq(opStore, 3'b001, 32'h0002_0002, 32'h0000_beef);
    sendReq(opLoad, 3'b010, 32'h0003_0000, 32'h0);
    sendReq(opLoad, 3'b010, 32'h0004_0000, 32'h0);
    drain();
    // Supervisor access ignores the user bit
    userMode = 1'b0;
    sendReq(opLoad, 3'b010, 32'h0003_0000, 32'h0);
    drain();
    flushTlb();
    sendReq(opLoad, 3'b010, 32'h1234_5010, 32'h0);
    sendReq(opStore, 3'b001, 32'h0002_0002, 32'h0000_1234);
    drain();
    translateOn = 1'b0;

    // Random mix under response back-pressure
    pressure = 1'b1;
    for (int n = 0; n < 200; n++) begin
      pick = $random(seed) & 15;
      adr  = $random(seed) & 32'h3ff;
      wd   = $random(seed);
      kind = $random(seed) & 3;
      if (pick < 6) begin
        sendReq(opLoad, loadKinds[$unsigned($random(seed)) % 5], adr, 32'h0);
      end else if (pick < 12) begin
        sendReq(opStore, (kind == 3) ? 3'd2 : 3'(kind), adr, wd);
      end else if (pick < 14) begin
        sendReq(opLr, 3'b010, adr & 32'h3c, 32'h0);
      end else begin
        sendReq(opSc, 3'b010, adr & 32'h3c, wd);
      end
    end
    drain();
    pressure = 1'b0;

    if (expQ.size() == 0 && busQ.size() == 0 && busCount == expBusCount) begin
      $display("TEST PASS");
      $finish;
    end else begin
      stopRun("Responses or bus accesses left unmatched at the end");
    end
  end

endmodule

// ==== dmem.f ====
+incdir+.
lsuPkg.sv
tlbPkg.sv
memStageIf.sv
accessCheck.sv
dtlb.sv
reservation.sv
busAccess.sv
dmem.sv
tbClock.sv
dmemTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the memory stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f dmem.f \
  --top-module dmemTb \
  -o dmemSim

./obj_dir/dmemSim
